/* squeeze/weights.mem */
// One row per input channel: lanes 7 down to 0, four hex digits each, lane 0 rightmost
07FFFC00100000100F00012308001234
07FFFC00F0000020F1000456F8000100
07FFFC00100000300E00078904000080
07FFFC00F0000040F2000ABCFC00FF80
07FFFC00100000500D000DEF02000040
07FFFC00F0000060F3000111FE000300
07FFFC00100000700C0002220100FD00
07FFFC00F0000080F4000333FF000010
07FFFC00100000900B00044400800020
07FFFC00F00000A0F5000555FF80FFC0
07FFFC00100000B00A0006660C000500
07FFFC00F00000C0F6000777F4000001
07FFFC00100000D0090008880A000600
07FFFC00F00000E0F7000999F600FA00
07FFFC00100000F008000AAA03000090
07FFFC00F0000100F8000BBBFD000111

/* squeeze/bias.mem */
// One signed 32-bit bias per lane, lane 0 first
00002000
FFFF0000
00010000
00000000
00100000
FFF00000
00000000
00004000

/* flist.f */
common/squeeze_pkg.sv
squeeze/squeeze_coeff_rom.sv
hw/mac_lane.sv
squeeze/squeeze_layer.sv
hw/ofm_buffer.sv
hw/squeeze_top.sv
bench/tb_squeeze.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run from the project root so the .mem paths resolve
cd "$(dirname "$0")" || exit 1
verilator --binary --timescale 1ns/1ps -Wno-fatal --top-module tb_squeeze -f flist.f || exit 1
out=$(./obj_dir/Vtb_squeeze)
echo "$out"
echo "$out" | grep -qx "TESTS PASSED" && exit 0 || exit 1

/* bench/tb_squeeze.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_squeeze;

	import squeeze_pkg::*;

	localparam int lane_w = $clog2(lanes);
	localparam int n_tests = 5;
	// Doubled budget of one padded layer per test
	localparam int watchdog_ns = n_tests * pixels * (channels + 20) * 2 * 10;

	logic clk = 1'b0;
	logic reset;
	logic ifm_valid;
	logic [data_w-1:0] ifm;
	logic finish_ack;
	logic [pix_addr_w-1:0] rd_pix;
	logic [lane_w-1:0] rd_lane;
	logic ofm_sample;
	logic [data_w-1:0] rd_data;
	logic layer_finish;

	squeeze_top dut0 (
		.clk(clk),
		.reset(reset),
		.ifm_valid(ifm_valid),
		.ifm(ifm),
		.finish_ack(finish_ack),
		.rd_pix(rd_pix),
		.rd_lane(rd_lane),
		.ofm_sample(ofm_sample),
		.rd_data(rd_data),
		.layer_finish(layer_finish)
	);

	////////////////////////////////////////////////////////////////////////////
	// Bench state
	////////////////////////////////////////////////////////////////////////////

	// Own copy of the coefficient images
	logic [lanes*data_w-1:0] w_mem [channels];
	logic [acc_w-1:0] b_mem [lanes];
	logic [data_w-1:0] pix_data [pixels][channels];
	logic [data_w-1:0] exp_out [pixels][lanes];
	// Cycle numbers at which ofm_sample has to be high
	int exp_q [$];
	int cyc = 0;
	integer seed = 36;
	int errors = 0;
	int err_mark = 0;
	int tests_run = 0;
	int tests_failed = 0;

	initial begin
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks and reference model
	////////////////////////////////////////////////////////////////////////////

	task automatic compare_data(input string name, input logic [data_w-1:0] got,
			input logic [data_w-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Bias plus dot product, then ReLU, saturation, truncation
	function automatic logic [data_w-1:0] model_out(input int p, input int l);
		acc_word_t a;
		logic signed [data_w-1:0] px;
		logic signed [data_w-1:0] wk;
		int prod;
		a.sum = b_mem[l];
		for (int c = 0; c < channels; c++) begin
			px = pix_data[p][c];
			wk = w_mem[c][l*data_w +: data_w];
			prod = px * wk;
			a.sum = a.sum + prod;
		end
		if (a.f.sign)
			return '0;
		else if (a.f.guard != 0)
			return 16'h7FFF;
		return {1'b0, a.f.mag};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers entered and left on a falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic apply_reset();
		reset = 1'b1;
		ifm_valid = 1'b0;
		finish_ack = 1'b0;
		exp_q.delete();
		repeat (5) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic fill_random();
		for (int p = 0; p < pixels; p++)
			for (int c = 0; c < channels; c++)
				pix_data[p][c] = data_w'($random(seed));
	endtask

	// Word lands on the next rising edge and a live last word predicts its sample
	task automatic drive_word(input logic [data_w-1:0] w, input bit last, input bit live);
		ifm = w;
		ifm_valid = 1'b1;
		if (last && live)
			exp_q.push_back(cyc + 3);
		@(negedge clk);
		ifm_valid = 1'b0;
	endtask

	task automatic stream_pixel(input int p, input bit gaps);
		for (int c = 0; c < channels; c++) begin
			// Idle stretch of 1 to 4 cycles about one word in four
			if (gaps && ($random(seed) & 3) == 0)
				repeat (($random(seed) & 3) + 1) @(negedge clk);
			drive_word(pix_data[p][c], c == channels - 1, 1'b1);
		end
	endtask

	task automatic read_word(input int p, input int l, output logic [data_w-1:0] d);
		rd_pix = pix_addr_w'(p);
		rd_lane = lane_w'(l);
		@(negedge clk);
		d = rd_data;
	endtask

	task automatic wait_finish();
		int n;
		n = 0;
		while (!layer_finish && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (!layer_finish) begin
			errors++;
			$display("layer_finish never rose after the last pixel at %0t", $time);
		end
	endtask

	// Reset, stream the whole layer, then read back every word
	task automatic run_layer(input bit gaps);
		logic [data_w-1:0] d;
		apply_reset();
		for (int p = 0; p < pixels; p++)
			for (int l = 0; l < lanes; l++)
				exp_out[p][l] = model_out(p, l);
		for (int p = 0; p < pixels; p++)
			stream_pixel(p, gaps);
		wait_finish();
		for (int p = 0; p < pixels; p++)
			for (int l = 0; l < lanes; l++) begin
				read_word(p, l, d);
				compare_data($sformatf("rd_data[%0d][%0d]", p, l), d, exp_out[p][l]);
			end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == err_mark) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		apply_reset();
		compare_flag("ofm_sample", ofm_sample, 1'b0);
		compare_flag("layer_finish", layer_finish, 1'b0);
		repeat (3) @(negedge clk);
		compare_flag("layer_finish", layer_finish, 1'b0);
		finish_test("reset_state");
	endtask

	task automatic test_corner_cases();
		logic [data_w-1:0] d;
		fill_random();
		// 1.0 in Q14 on channel 0 passes lane 0's weight 0x1234 through
		for (int c = 0; c < channels; c++) begin
			pix_data[0][c] = '0;
			pix_data[1][c] = 16'h7FFF;
		end
		pix_data[0][0] = 16'h4000;
		run_layer(1'b0);
		read_word(0, 0, d);
		compare_data("rd_data exact lane 0", d, 16'h1234);
		// Full-scale pixel overflows lane 7 and drives lane 6 negative
		read_word(1, 7, d);
		compare_data("rd_data saturated lane 7", d, 16'h7FFF);
		read_word(1, 6, d);
		compare_data("rd_data relu lane 6", d, 16'h0000);
		finish_test("corner_cases");
	endtask

	task automatic test_finish_handshake();
		apply_reset();
		fill_random();
		for (int p = 0; p < pixels - 1; p++)
			stream_pixel(p, 1'b0);
		repeat (4) @(negedge clk);
		compare_flag("layer_finish", layer_finish, 1'b0);
		stream_pixel(pixels - 1, 1'b0);
		repeat (2) @(negedge clk);
		// Flag follows the 16th sample by one cycle
		compare_flag("layer_finish", layer_finish, 1'b0);
		@(negedge clk);
		compare_flag("layer_finish", layer_finish, 1'b1);
		// Late words must not produce a sample
		for (int c = 0; c < channels; c++)
			drive_word(data_w'($random(seed)), c == channels - 1, 1'b0);
		repeat (6) @(negedge clk);
		compare_flag("layer_finish", layer_finish, 1'b1);
		finish_ack = 1'b1;
		@(negedge clk);
		finish_ack = 1'b0;
		compare_flag("layer_finish", layer_finish, 1'b0);
		repeat (5) @(negedge clk);
		compare_flag("layer_finish", layer_finish, 1'b0);
		finish_test("finish_handshake");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Processes
	////////////////////////////////////////////////////////////////////////////

	// ofm_sample checked every cycle against the predicted cycle list
	initial begin : sample_monitor
		logic exp_now;
		forever begin
			@(negedge clk);
			exp_now = 1'b0;
			if (exp_q.size() > 0)
				exp_now = (exp_q[0] == cyc);
			compare_flag("ofm_sample", ofm_sample, exp_now);
			if (exp_now)
				void'(exp_q.pop_front());
		end
	end

	initial begin
		#(watchdog_ns);
		$display("Watchdog expired before the tests completed");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		reset = 1'b1;
		ifm_valid = 1'b0;
		ifm = '0;
		finish_ack = 1'b0;
		rd_pix = '0;
		rd_lane = '0;
		$readmemh(weight_file, w_mem);
		$readmemh(bias_file, b_mem);
		test_reset_state();
		fill_random();
		run_layer(1'b0);
		finish_test("stream_full");
		fill_random();
		run_layer(1'b1);
		finish_test("stream_gaps");
		test_corner_cases();
		test_finish_handshake();
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/squeeze_top.sv */
`timescale 1ns/1ps
`default_nettype none

module squeeze_top (
	input logic clk,
	input logic reset,
	// Input feature map, one channel word per valid cycle
	input logic ifm_valid,
	input logic [squeeze_pkg::data_w-1:0] ifm,
	// Downstream acknowledge of the finish flag
	input logic finish_ack,
	// Host readback address
	input logic [squeeze_pkg::pix_addr_w-1:0] rd_pix,
	input logic [$clog2(squeeze_pkg::lanes)-1:0] rd_lane,
	output logic ofm_sample,
	output logic [squeeze_pkg::data_w-1:0] rd_data,
	output logic layer_finish
);

	import squeeze_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Layer to buffer
	////////////////////////////////////////////////////////////////////////////

	// One output pixel, all lanes
	logic [lanes-1:0][data_w-1:0] ofm;
	logic sample;

	assign ofm_sample = sample;

	// Squeeze engine
	squeeze_layer u_layer (
		.clk(clk),
		.reset(reset),
		.ifm_valid(ifm_valid),
		.ifm(ifm),
		.finish_ack(finish_ack),
		.ofm_sample(sample),
		.ofm(ofm),
		.layer_finish(layer_finish)
	);

	// Output map store
	ofm_buffer u_buf (
		.clk(clk),
		.reset(reset),
		.ofm_sample(sample),
		.ofm(ofm),
		.rd_pix(rd_pix),
		.rd_lane(rd_lane),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

/* hw/ofm_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module ofm_buffer (
	input logic clk,
	input logic reset,
	input logic ofm_sample,
	input logic [squeeze_pkg::lanes-1:0][squeeze_pkg::data_w-1:0] ofm,
	input logic [squeeze_pkg::pix_addr_w-1:0] rd_pix,
	input logic [$clog2(squeeze_pkg::lanes)-1:0] rd_lane,
	output logic [squeeze_pkg::data_w-1:0] rd_data
);

	import squeeze_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Storage, one entry per output pixel holding all lanes
	////////////////////////////////////////////////////////////////////////////

	logic [lanes-1:0][data_w-1:0] mem [pixels];

	// Next pixel slot to fill
	logic [pix_addr_w-1:0] wr_pix;

	always_ff @(posedge clk) begin
		if (reset)
			wr_pix <= '0;
		else if (ofm_sample)
			wr_pix <= wr_pix + 1'b1;
	end

	// All eight lanes land together
	always_ff @(posedge clk) begin
		if (ofm_sample)
			mem[wr_pix] <= ofm;
	end

	////////////////////////////////////////////////////////////////////////////
	// Host read port
	////////////////////////////////////////////////////////////////////////////

	// Registered, data follows the address by one cycle
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_pix][rd_lane];
	end

endmodule

`default_nettype wire

/* squeeze/squeeze_layer.sv */
`timescale 1ns/1ps
`default_nettype none

module squeeze_layer (
	input logic clk,
	input logic reset,
	input logic ifm_valid,
	input logic [squeeze_pkg::data_w-1:0] ifm,
	input logic finish_ack,
	output logic ofm_sample,
	output logic [squeeze_pkg::lanes-1:0][squeeze_pkg::data_w-1:0] ofm,
	output logic layer_finish
);

	import squeeze_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Input acceptance and channel tracking
	////////////////////////////////////////////////////////////////////////////

	logic [chan_addr_w-1:0] chan_cnt;
	logic [pix_addr_w-1:0] in_pix;
	// All pixels of the layer have been taken in
	logic in_done;
	logic accept;
	logic is_first;
	logic is_last;

	// Late words are dropped once the layer has its pixels
	assign accept = ifm_valid && !in_done;
	assign is_first = (chan_cnt == '0);
	assign is_last = (chan_cnt == chan_addr_w'(channels - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			chan_cnt <= '0;
			in_pix <= '0;
			in_done <= 1'b0;
		end else if (accept) begin
			// Wraps to 0 after the last channel
			chan_cnt <= chan_cnt + 1'b1;
			if (is_last) begin
				in_pix <= in_pix + 1'b1;
				if (in_pix == pix_addr_w'(pixels - 1))
					in_done <= 1'b1;
			end
		end
	end

	// Weight row for the channel being accepted
	logic [chan_addr_w-1:0] chan_addr;
	logic [lanes-1:0][data_w-1:0] rom_weights;
	logic [lanes-1:0][acc_w-1:0] rom_biases;

	assign chan_addr = chan_cnt;

	squeeze_coeff_rom u_rom (
		.chan_addr(chan_addr),
		.weights(rom_weights),
		.biases(rom_biases)
	);

	////////////////////////////////////////////////////////////////////////////
	// Stage 1 operand registers
	////////////////////////////////////////////////////////////////////////////

	logic s1_valid;
	logic s1_first;
	logic s1_last;
	logic [data_w-1:0] s1_pix;
	logic [lanes-1:0][data_w-1:0] s1_ker;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s1_first <= 1'b0;
			s1_last <= 1'b0;
		end else begin
			s1_valid <= accept;
			s1_first <= accept && is_first;
			s1_last <= accept && is_last;
		end
	end

	// Operands only move with an accepted word
	always_ff @(posedge clk) begin
		if (accept) begin
			s1_pix <= ifm;
			s1_ker <= rom_weights;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage 2 MAC lanes
	////////////////////////////////////////////////////////////////////////////

	logic [lanes-1:0][acc_w-1:0] acc;
	// Marks the cycle where acc holds a finished pixel
	logic s2_last;

	for (genvar i = 0; i < lanes; i++) begin : g_lane
		mac_lane u_mac (
			.clk(clk),
			.reset(reset),
			.en(s1_valid),
			.first(s1_first),
			.pix(s1_pix),
			.ker(s1_ker[i]),
			.acc_out(acc[i])
		);
	end

	always_ff @(posedge clk) begin
		if (reset)
			s2_last <= 1'b0;
		else
			s2_last <= s1_last;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage 3 bias, ReLU and requantization
	////////////////////////////////////////////////////////////////////////////

	acc_word_t biased [lanes];
	logic [lanes-1:0][data_w-1:0] requant;

	always_comb begin
		for (int i = 0; i < lanes; i++) begin
			biased[i].sum = $signed(acc[i]) + $signed(rom_biases[i]);
			// ReLU clamps negatives
			if (biased[i].f.sign)
				requant[i] = '0;
			// Saturate when too large for 15 bits
			else if (|biased[i].f.guard)
				requant[i] = {1'b0, {(data_w-1){1'b1}}};
			else
				requant[i] = {1'b0, biased[i].f.mag};
		end
	end

	always_ff @(posedge clk) begin
		if (s2_last)
			ofm <= requant;
	end

	always_ff @(posedge clk) begin
		if (reset)
			ofm_sample <= 1'b0;
		else
			ofm_sample <= s2_last;
	end

	////////////////////////////////////////////////////////////////////////////
	// Layer end and finish handshake
	////////////////////////////////////////////////////////////////////////////

	logic [pix_addr_w-1:0] sample_cnt;
	logic layer_done;
	logic ack_seen;

	always_ff @(posedge clk) begin
		if (reset) begin
			sample_cnt <= '0;
			layer_done <= 1'b0;
			ack_seen <= 1'b0;
		end else begin
			if (ofm_sample) begin
				sample_cnt <= sample_cnt + 1'b1;
				if (sample_cnt == pix_addr_w'(pixels - 1))
					layer_done <= 1'b1;
			end
			// Ack only counts once the layer is done
			if (layer_done && finish_ack)
				ack_seen <= 1'b1;
		end
	end

	// Held until the downstream side acknowledges
	assign layer_finish = layer_done && !ack_seen;

endmodule

`default_nettype wire

/* hw/mac_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_lane (
	input logic clk,
	input logic reset,
	input logic en,
	input logic first,
	input logic signed [squeeze_pkg::data_w-1:0] pix,
	input logic signed [squeeze_pkg::data_w-1:0] ker,
	output logic [squeeze_pkg::acc_w-1:0] acc_out
);

	import squeeze_pkg::*;

	// Full precision product, sign extended to the accumulator
	logic signed [acc_w-1:0] prod;
	logic signed [acc_w-1:0] acc;

	assign prod = pix * ker;

	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
		end else if (en) begin
			// First channel of a pixel starts a new sum
			if (first)
				acc <= prod;
			else
				acc <= acc + prod;
		end
	end

	assign acc_out = acc;

endmodule

`default_nettype wire

/* squeeze/squeeze_coeff_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module squeeze_coeff_rom (
	input logic [squeeze_pkg::chan_addr_w-1:0] chan_addr,
	output logic [squeeze_pkg::lanes-1:0][squeeze_pkg::data_w-1:0] weights,
	output logic [squeeze_pkg::lanes-1:0][squeeze_pkg::acc_w-1:0] biases
);

	import squeeze_pkg::*;

	// One row per input channel, lane 0 in the low bits
	logic [lanes*data_w-1:0] weight_mem [channels];
	// One bias per output lane
	logic [acc_w-1:0] bias_mem [lanes];

	// Images loaded once at elaboration
	initial begin
		$readmemh(weight_file, weight_mem);
		$readmemh(bias_file, bias_mem);
	end

	// Asynchronous row read, the layer registers it
	assign weights = weight_mem[chan_addr];

	// Bias words are constant per lane
	always_comb begin
		for (int i = 0; i < lanes; i++) begin
			biases[i] = bias_mem[i];
		end
	end

endmodule

`default_nettype wire

/* common/squeeze_pkg.sv */
`default_nettype none

package squeeze_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////////////////////////////////////////

	// Pixels, weights and requantized outputs
	localparam int data_w = 16;
	// Accumulator and bias width
	localparam int acc_w = 32;

	////////////////////////////////////////////////////////////////////////////
	// Layer geometry
	////////////////////////////////////////////////////////////////////////////

	// One lane per output channel
	localparam int lanes = 8;
	localparam int channels = 16;
	localparam int out_dim = 4;
	localparam int pixels = out_dim * out_dim;
	localparam int chan_addr_w = 4;
	localparam int pix_addr_w = 4;

	// Q-format fraction dropped when going back to 16 bits
	localparam int frac_bits = 14;

	// Coefficient images, relative to the run directory
	localparam string weight_file = "squeeze/weights.mem";
	localparam string bias_file = "squeeze/bias.mem";

	////////////////////////////////////////////////////////////////////////////
	// Accumulator word
	////////////////////////////////////////////////////////////////////////////

	// Same 32 bits seen as a signed sum or as requantization fields
	typedef union packed {
		logic signed [acc_w-1:0] sum;
		struct packed {
			logic sign;
			// Bits above the 15-bit output magnitude
			logic [acc_w-data_w-frac_bits-1:0] guard;
			logic [data_w-2:0] mag;
			logic [frac_bits-1:0] frac;
		} f;
	} acc_word_t;

endpackage

`default_nettype wire
